//--- rs_station.f
hdl/rs_pkg.sv
hdl/rs_operand_bypass.sv
hdl/rs_entry.sv
hdl/rs_alloc.sv
hdl/rs_issue_select.sv
hdl/rs_station.sv
testbench/rs_station_assertions.sv
testbench/rs_station_tb.sv

//--- testbench/rs_station_tb.sv
/* rs_station_tb: random dispatch, CDB, availability and flush traffic
   checked every cycle against a model of the station */
module rs_station_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 3;
	localparam int NUM_CYCLES = 2000;
	localparam int TAG_POOL_W = 3; // tags 0..7 so wakeups are frequent
	localparam int WATCHDOG_NS = (RESET_CYCLES + NUM_CYCLES) * CLK_PERIOD + 200;

	logic clock = 1'b0;
	logic arst_n;
	logic [1:0] dispatch_valid;
	rs_pkg::rs_inst_t [1:0] dispatch_inst;
	rs_pkg::cdb_t [rs_pkg::NUM_CDB-1:0] cdb;
	logic [rs_pkg::NUM_FU-1:0] fu_available;
	logic [1:0] flush_thread;
	logic [rs_pkg::NUM_FU-1:0] issue_valid;
	rs_pkg::rs_issue_t [rs_pkg::NUM_FU-1:0] issue;
	logic rs_full;
	logic rs_almost_full;

	logic [31:0] lfsr = 32'h72c2_f459;
	logic model_busy [rs_pkg::RS_SIZE];
	rs_pkg::rs_inst_t model_inst [rs_pkg::RS_SIZE];
	logic [rs_pkg::RS_SIZE-1:0] exp_grant; // entries the model issues this cycle
	int issue_errors = 0;
	int flag_errors = 0;
	int sva_fails;

	rs_station DUT (
		.clock(clock),
		.arst_n(arst_n),
		.dispatch_valid(dispatch_valid),
		.dispatch_inst(dispatch_inst),
		.cdb(cdb),
		.fu_available(fu_available),
		.flush_thread(flush_thread),
		.issue_valid(issue_valid),
		.issue(issue),
		.rs_full(rs_full),
		.rs_almost_full(rs_almost_full)
	);

	always #(CLK_PERIOD / 2) clock = ~clock;

	//////////////////////////////
	// random source
	function automatic logic next_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // taps 32 22 2 1
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] val;
		val = '0;
		for (int k = 0; k < n; k++) begin
			val = {val[62:0], next_bit()};
		end
		return val;
	endfunction

	function automatic rs_pkg::operand_t make_operand();
		rs_pkg::operand_t op;
		op.ready = next_bit();
		op.value = op.ready ? rand_bits(64) : rand_bits(TAG_POOL_W); // waiting tag in low bits
		return op;
	endfunction

	function automatic rs_pkg::rs_inst_t make_inst();
		rs_pkg::rs_inst_t inst;
		logic [1:0] cls;
		inst.opa = make_operand();
		inst.opb = make_operand();
		inst.dest_tag = rs_pkg::TAG_W'(rand_bits(rs_pkg::TAG_W));
		inst.rob_idx = rs_pkg::ROB_W'(rand_bits(rs_pkg::ROB_W));
		cls = 2'(rand_bits(2));
		if (cls == 2'd3) begin
			cls = 2'd1;
		end
		inst.fu_class = rs_pkg::fu_class_e'(cls);
		inst.alu_func = rs_pkg::ALU_FUNC_W'(rand_bits(rs_pkg::ALU_FUNC_W));
		return inst;
	endfunction

	//////////////////////////////
	// reference model
	function automatic rs_pkg::fu_class_e class_of_port(input int p);
		case (p)
			0, 3: return rs_pkg::FU_MULT;
			1, 4: return rs_pkg::FU_ALU;
			default: return rs_pkg::FU_MEM;
		endcase
	endfunction

	// bus 0 is looked at first and wins a double match
	function automatic rs_pkg::operand_t wake(input rs_pkg::operand_t op);
		if (op.ready) begin
			return op;
		end
		if (cdb[0].valid && cdb[0].tag == op.value[rs_pkg::TAG_W-1:0]) begin
			op.value = cdb[0].value;
			op.ready = 1'b1;
		end else if (cdb[1].valid && cdb[1].tag == op.value[rs_pkg::TAG_W-1:0]) begin
			op.value = cdb[1].value;
			op.ready = 1'b1;
		end
		return op;
	endfunction

	function automatic int free_count();
		int n;
		n = 0;
		for (int i = 0; i < rs_pkg::RS_SIZE; i++) begin
			n += model_busy[i] ? 0 : 1;
		end
		return n;
	endfunction

	// state change at a rising edge from the inputs of the ending cycle
	function automatic void update_model();
		logic [rs_pkg::RS_SIZE-1:0] old_free;
		int slot [2];
		slot[0] = -1;
		slot[1] = -1;
		for (int i = 0; i < rs_pkg::RS_SIZE; i++) begin
			old_free[i] = !model_busy[i];
			if (old_free[i] && slot[0] < 0) begin
				slot[0] = i;
			end else if (old_free[i] && slot[1] < 0) begin
				slot[1] = i;
			end
		end
		for (int i = 0; i < rs_pkg::RS_SIZE; i++) begin
			if (model_busy[i]) begin
				if (exp_grant[i] || flush_thread[model_inst[i].rob_idx[rs_pkg::ROB_W-1]]) begin
					model_busy[i] = 1'b0;
				end else begin
					model_inst[i].opa = wake(model_inst[i].opa);
					model_inst[i].opb = wake(model_inst[i].opb);
				end
			end
		end
		for (int s = 0; s < 2; s++) begin
			if (dispatch_valid[s] && slot[s] >= 0) begin
				model_inst[slot[s]] = dispatch_inst[s];
				model_inst[slot[s]].opa = wake(dispatch_inst[s].opa); // same cycle capture
				model_inst[slot[s]].opb = wake(dispatch_inst[s].opb);
				model_busy[slot[s]] = 1'b1;
			end
		end
	endfunction

	//////////////////////////////
	// checks
	task automatic report_mismatch(input string name, input logic [255:0] exp,
			input logic [255:0] act);
		$display("ERROR %s: expected %0h actual %0h", name, exp, act);
	endtask

	task automatic check_outputs();
		logic [rs_pkg::NUM_FU-1:0] exp_valid;
		rs_pkg::rs_issue_t exp_issue [rs_pkg::NUM_FU];
		int n_free;
		exp_grant = '0;
		exp_valid = '0;
		for (int p = 0; p < rs_pkg::NUM_FU; p++) begin
			exp_issue[p] = '0;
			for (int i = 0; i < rs_pkg::RS_SIZE && fu_available[p] && !exp_valid[p]; i++) begin
				if (model_busy[i] && model_inst[i].opa.ready && model_inst[i].opb.ready &&
						!exp_grant[i] && model_inst[i].fu_class == class_of_port(p)) begin
					exp_valid[p] = 1'b1;
					exp_grant[i] = 1'b1;
					exp_issue[p].opa_value = model_inst[i].opa.value;
					exp_issue[p].opb_value = model_inst[i].opb.value;
					exp_issue[p].dest_tag = model_inst[i].dest_tag;
					exp_issue[p].rob_idx = model_inst[i].rob_idx;
					exp_issue[p].alu_func = model_inst[i].alu_func;
				end
			end
		end
		n_free = free_count();
		if (issue_valid !== exp_valid) begin
			issue_errors++;
			report_mismatch("issue_valid", exp_valid, issue_valid);
		end
		for (int p = 0; p < rs_pkg::NUM_FU; p++) begin
			if (issue[p] !== exp_issue[p]) begin
				issue_errors++;
				report_mismatch($sformatf("issue[%0d]", p), exp_issue[p], issue[p]);
			end
		end
		if (rs_full !== (n_free == 0)) begin
			flag_errors++;
			report_mismatch("rs_full", n_free == 0, rs_full);
		end
		if (rs_almost_full !== (n_free <= 1)) begin
			flag_errors++;
			report_mismatch("rs_almost_full", n_free <= 1, rs_almost_full);
		end
	endtask

	//////////////////////////////
	// stimulus
	task automatic drive_stimulus();
		int n_free;
		logic v0;
		logic v1;
		rs_pkg::cdb_t bus;
		n_free = free_count(); // upstream sees the flags of the coming cycle
		v0 = n_free >= 1 && next_bit();
		v1 = v0 && n_free >= 2 && next_bit();
		dispatch_valid <= {v1, v0};
		dispatch_inst[0] <= make_inst();
		dispatch_inst[1] <= make_inst();
		for (int b = 0; b < rs_pkg::NUM_CDB; b++) begin
			bus.valid = rand_bits(2) != 0;
			bus.tag = rs_pkg::TAG_W'(rand_bits(TAG_POOL_W));
			bus.value = rand_bits(64);
			cdb[b] <= bus;
		end
		for (int p = 0; p < rs_pkg::NUM_FU; p++) begin
			fu_available[p] <= rand_bits(2) != 0;
		end
		flush_thread <= (rand_bits(4) == 0) ? 2'(rand_bits(2)) : 2'b00;
	endtask

	initial begin
		arst_n = 1'b0;
		dispatch_valid = '0;
		dispatch_inst = '0;
		cdb = '0;
		fu_available = '1; // every port open while reset holds the station empty
		flush_thread = '0;
		exp_grant = '0;
		for (int i = 0; i < rs_pkg::RS_SIZE; i++) begin
			model_busy[i] = 1'b0;
			model_inst[i] = '0;
		end
		repeat (RESET_CYCLES) begin
			@(negedge clock);
			check_outputs(); // empty station with both flags low
			@(posedge clock);
		end
		arst_n <= 1'b1;
		for (int c = 0; c < NUM_CYCLES; c++) begin
			drive_stimulus();
			@(negedge clock);
			check_outputs();
			@(posedge clock);
			update_model();
		end
		sva_fails = DUT.u_select.u_sva.fail_count;
		$display("issue errors %0d, flag errors %0d, assertion failures %0d",
			issue_errors, flag_errors, sva_fails);
		if (issue_errors + flag_errors + sva_fails == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("run timed out after %0d ns before all cycles were checked", WATCHDOG_NS);
		$display("Some tests failed");
		$finish;
	end

endmodule

//--- testbench/rs_station_assertions.sv
/* rs_station_assertions: grant, availability and reset rules of the
   issue selector */
module rs_station_assertions (
	input logic clock,
	input logic arst_n,
	input logic [rs_pkg::RS_SIZE-1:0] grant,
	input logic [rs_pkg::NUM_FU-1:0] issue_valid,
	input logic [rs_pkg::NUM_FU-1:0] fu_available
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0; // read by the testbench at the end of the run

	//////////////////////////////
	// port rules
	// one grant bit per issued port, so no entry feeds two ports
	a_one_port_per_entry: assert property (@(posedge clock) disable iff (!arst_n)
			$countones(grant) == $countones(issue_valid))
		else begin
			$error("grant count differs from issue count, an entry went to two ports");
			fail_count++;
		end

	a_issue_needs_unit: assert property (@(posedge clock) disable iff (!arst_n)
			(issue_valid & ~fu_available) == '0)
		else begin
			$error("issue_valid raised on a port whose unit is not available");
			fail_count++;
		end

	// station is empty while reset is held
	a_idle_in_reset: assert property (@(posedge clock) !arst_n |-> issue_valid == '0)
		else begin
			$error("issue_valid set while in reset");
			fail_count++;
		end

endmodule

bind rs_issue_select rs_station_assertions u_sva (
	.clock(rs_station.clock),
	.arst_n(rs_station.arst_n),
	.grant(grant),
	.issue_valid(issue_valid),
	.fu_available(fu_available)
);

//--- hdl/rs_station.sv
/* rs_station: dual dispatch reservation station with CDB wakeup, six
   unit ports and per-thread flush */
module rs_station (
	input logic clock,
	input logic arst_n,
	input logic [rs_pkg::NUM_DISPATCH-1:0] dispatch_valid,
	input rs_pkg::rs_inst_t [rs_pkg::NUM_DISPATCH-1:0] dispatch_inst,
	input rs_pkg::cdb_t [rs_pkg::NUM_CDB-1:0] cdb,
	input logic [rs_pkg::NUM_FU-1:0] fu_available, // 0,3 mult 1,4 alu 2,5 mem
	input logic [rs_pkg::NUM_THREAD-1:0] flush_thread,
	output logic [rs_pkg::NUM_FU-1:0] issue_valid,
	output rs_pkg::rs_issue_t [rs_pkg::NUM_FU-1:0] issue,
	output logic rs_full,
	output logic rs_almost_full
);

	rs_pkg::rs_inst_t [rs_pkg::NUM_DISPATCH-1:0] patched_inst;
	logic [rs_pkg::RS_SIZE-1:0] load_slot0;
	logic [rs_pkg::RS_SIZE-1:0] load_slot1;
	logic [rs_pkg::RS_SIZE-1:0] busy;
	logic [rs_pkg::RS_SIZE-1:0] ready;
	logic [rs_pkg::RS_SIZE-1:0] grant;
	rs_pkg::rs_inst_t [rs_pkg::RS_SIZE-1:0] entry_inst;

	//////////////////////////////
	// dispatch side
	rs_operand_bypass u_bypass (
		.dispatch_inst(dispatch_inst),
		.cdb(cdb),
		.patched_inst(patched_inst)
	);

	rs_alloc u_alloc (
		.busy(busy),
		.dispatch_valid(dispatch_valid),
		.load_slot0(load_slot0),
		.load_slot1(load_slot1),
		.rs_full(rs_full),
		.rs_almost_full(rs_almost_full)
	);

	//////////////////////////////
	// entry array
	for (genvar i = 0; i < rs_pkg::RS_SIZE; i++) begin : g_entry
		rs_entry u_entry (
			.clock(clock),
			.arst_n(arst_n),
			.load(load_slot0[i] | load_slot1[i]),
			.load_inst(load_slot0[i] ? patched_inst[0] : patched_inst[1]), // one-hot per slot
			.cdb(cdb),
			.issue_grant(grant[i]),
			.flush_thread(flush_thread),
			.busy(busy[i]),
			.ready(ready[i]),
			.entry_inst(entry_inst[i])
		);
	end

	//////////////////////////////
	// issue side
	rs_issue_select u_select (
		.ready(ready),
		.entry_inst(entry_inst),
		.fu_available(fu_available),
		.grant(grant),
		.issue_valid(issue_valid),
		.issue(issue)
	);

endmodule

//--- hdl/rs_issue_select.sv
/* rs_issue_select: gives every available unit port the lowest ready entry
   of its class and builds the issue payloads and entry grants */
module rs_issue_select (
	input logic [rs_pkg::RS_SIZE-1:0] ready,
	input rs_pkg::rs_inst_t [rs_pkg::RS_SIZE-1:0] entry_inst,
	input logic [rs_pkg::NUM_FU-1:0] fu_available,
	output logic [rs_pkg::RS_SIZE-1:0] grant,
	output logic [rs_pkg::NUM_FU-1:0] issue_valid,
	output rs_pkg::rs_issue_t [rs_pkg::NUM_FU-1:0] issue
);

	// strip the ready bits and class, the unit only needs values
	function automatic rs_pkg::rs_issue_t to_issue(input rs_pkg::rs_inst_t inst);
		rs_pkg::rs_issue_t pkt;
		pkt.opa_value = inst.opa.value;
		pkt.opb_value = inst.opb.value;
		pkt.dest_tag = inst.dest_tag;
		pkt.rob_idx = inst.rob_idx;
		pkt.alu_func = inst.alu_func;
		return pkt;
	endfunction

	//////////////////////////////
	// port arbitration
	// ports are walked in index order and each one skips entries already
	// granted to an earlier port, so the two ports of a class end up
	// with the two lowest ready entries of that class
	always_comb begin
		grant = '0;
		for (int p = 0; p < rs_pkg::NUM_FU; p++) begin
			issue_valid[p] = 1'b0;
			issue[p] = '0; // idle port drives zeros
			if (fu_available[p]) begin
				for (int i = 0; i < rs_pkg::RS_SIZE; i++) begin
					if (!issue_valid[p] && ready[i] && !grant[i] &&
							entry_inst[i].fu_class == rs_pkg::fu_class_of_port(p)) begin
						issue_valid[p] = 1'b1;
						grant[i] = 1'b1; // frees the entry at the next edge
						issue[p] = to_issue(entry_inst[i]);
					end
				end
			end
		end
	end

endmodule

//--- hdl/rs_alloc.sv
/* rs_alloc: finds the two lowest free entries for the dispatch slots and
   derives the full and almost full flags from the free count */
module rs_alloc (
	input logic [rs_pkg::RS_SIZE-1:0] busy,
	input logic [rs_pkg::NUM_DISPATCH-1:0] dispatch_valid,
	output logic [rs_pkg::RS_SIZE-1:0] load_slot0,
	output logic [rs_pkg::RS_SIZE-1:0] load_slot1,
	output logic rs_full,
	output logic rs_almost_full
);

	logic [rs_pkg::RS_SIZE-1:0] free;
	logic [rs_pkg::RS_SIZE-1:0] pick0;
	logic [rs_pkg::RS_SIZE-1:0] free_rest; // free entries minus slot 0 choice
	logic [rs_pkg::RS_SIZE-1:0] pick1;
	logic [rs_pkg::CNT_W-1:0] free_cnt;

	//////////////////////////////
	// two stage priority finder
	always_comb begin
		free = ~busy;
		pick0 = free & (~free + 1'b1);          // isolate lowest set bit
		free_rest = free & ~pick0;
		pick1 = free_rest & (~free_rest + 1'b1);
	end

	// slot 1 is never raised alone, so its pick can skip slot 0 blindly
	assign load_slot0 = dispatch_valid[0] ? pick0 : '0;
	assign load_slot1 = dispatch_valid[1] ? pick1 : '0;

	//////////////////////////////
	// occupancy
	always_comb begin
		free_cnt = '0;
		for (int i = 0; i < rs_pkg::RS_SIZE; i++) begin
			if (free[i]) begin
				free_cnt = free_cnt + 1'b1;
			end
		end
	end

	assign rs_full = (free_cnt == 0);
	assign rs_almost_full = (free_cnt <= 1); // room for one dispatch at most

endmodule

//--- hdl/rs_entry.sv
/* rs_entry: one reservation station slot, holds an instruction, snoops
   the CDBs for missing operands and frees on issue or thread flush */
module rs_entry (
	input logic clock,
	input logic arst_n,
	input logic load,
	input rs_pkg::rs_inst_t load_inst,
	input rs_pkg::cdb_t [rs_pkg::NUM_CDB-1:0] cdb,
	input logic issue_grant,
	input logic [rs_pkg::NUM_THREAD-1:0] flush_thread,
	output logic busy,
	output logic ready,
	output rs_pkg::rs_inst_t entry_inst
);

	logic thread;    // owning thread of the held instruction
	logic flush_hit;
	logic clear;

	//////////////////////////////
	// free conditions
	assign thread = entry_inst.rob_idx[rs_pkg::ROB_W-1];
	assign flush_hit = flush_thread[thread];
	assign clear = busy & (issue_grant | flush_hit); // nothing to free when idle

	// load beats clear, the allocator only loads idle entries so a
	// flush can never hit the instruction written at the same edge
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
		end else if (load) begin
			busy <= 1'b1;
		end else if (clear) begin
			busy <= 1'b0;
		end
	end

	//////////////////////////////
	// payload and wakeup
	always_ff @(posedge clock) begin
		if (load) begin
			entry_inst <= load_inst; // operands already patched by the bypass
		end else begin
			// waiting operands pick up a matching result
			entry_inst.opa <= rs_pkg::capture_operand(entry_inst.opa, cdb);
			entry_inst.opb <= rs_pkg::capture_operand(entry_inst.opb, cdb);
		end
	end

	// ready only from registered state, so a wakeup shows one cycle later
	assign ready = busy & entry_inst.opa.ready & entry_inst.opb.ready;

endmodule

//--- hdl/rs_operand_bypass.sv
/* rs_operand_bypass: patches the operands of both dispatch slots with
   results that appear on the CDBs in the dispatch cycle itself */
module rs_operand_bypass (
	input rs_pkg::rs_inst_t [rs_pkg::NUM_DISPATCH-1:0] dispatch_inst,
	input rs_pkg::cdb_t [rs_pkg::NUM_CDB-1:0] cdb,
	output rs_pkg::rs_inst_t [rs_pkg::NUM_DISPATCH-1:0] patched_inst
);

	//////////////////////////////
	// per slot capture
	// without this an operand produced in the dispatch cycle would be
	// missed, since the entry only snoops from the next cycle on
	always_comb begin
		for (int s = 0; s < rs_pkg::NUM_DISPATCH; s++) begin
			patched_inst[s] = dispatch_inst[s]; // dest, rob, class, func pass as is
			patched_inst[s].opa = rs_pkg::capture_operand(dispatch_inst[s].opa, cdb);
			patched_inst[s].opb = rs_pkg::capture_operand(dispatch_inst[s].opb, cdb);
		end
	end

endmodule

//--- hdl/rs_pkg.sv
/* rs_pkg: sizes, field widths, unit classes and the packed types shared
   by every block of the dual-dispatch reservation station */
package rs_pkg;

	//////////////////////////////
	// sizes and widths
	localparam int RS_SIZE = 8;
	localparam int PRF_SIZE = 64;
	localparam int TAG_W = $clog2(PRF_SIZE);
	localparam int ROB_SIZE = 32;             // entries per thread
	localparam int ROB_W = $clog2(ROB_SIZE) + 1; // msb selects the thread
	localparam int XLEN = 64;
	localparam int NUM_CDB = 2;
	localparam int NUM_FU = 6;
	localparam int NUM_DISPATCH = 2;
	localparam int NUM_THREAD = 2;
	localparam int ALU_FUNC_W = 5;
	localparam int CNT_W = $clog2(RS_SIZE + 1); // free entry counter

	typedef enum logic [1:0] {
		FU_MULT = 2'd0,
		FU_ALU  = 2'd1,
		FU_MEM  = 2'd2
	} fu_class_e;

	//////////////////////////////
	// packed types
	// while not ready the low TAG_W bits of value hold the awaited tag
	typedef struct packed {
		logic [XLEN-1:0] value;
		logic ready;
	} operand_t;

	typedef struct packed {
		logic valid;
		logic [TAG_W-1:0] tag;
		logic [XLEN-1:0] value;
	} cdb_t;

	typedef struct packed {
		operand_t opa;
		operand_t opb;
		logic [TAG_W-1:0] dest_tag;
		logic [ROB_W-1:0] rob_idx;
		fu_class_e fu_class;
		logic [ALU_FUNC_W-1:0] alu_func; // opaque to the station
	} rs_inst_t;

	typedef struct packed {
		logic [XLEN-1:0] opa_value;
		logic [XLEN-1:0] opb_value;
		logic [TAG_W-1:0] dest_tag;
		logic [ROB_W-1:0] rob_idx;
		logic [ALU_FUNC_W-1:0] alu_func;
	} rs_issue_t;

	// ports 0,3 mult  1,4 alu  2,5 mem
	function automatic fu_class_e fu_class_of_port(input int port);
		logic [1:0] code;
		code = 2'(port % 3);
		return fu_class_e'(code);
	endfunction

	// tag match against the result buses, bus 0 has the last word
	function automatic operand_t capture_operand(input operand_t op,
			input cdb_t [NUM_CDB-1:0] bus);
		operand_t res;
		res = op;
		if (!op.ready) begin
			for (int b = NUM_CDB - 1; b >= 0; b--) begin
				if (bus[b].valid && bus[b].tag == op.value[TAG_W-1:0]) begin
					res.value = bus[b].value;
					res.ready = 1'b1;
				end
			end
		end
		return res;
	endfunction

endpackage
